//--- common/lsd_pkg.sv
package lsd_pkg;

	localparam int lat_depth   = 4;
	localparam int fetch_width = 4;
	localparam int buffer_size = 64;

	typedef logic [15:0] addr_t;

	// slot[0] is the oldest and sits in the top bits
	typedef struct packed {
		addr_t [0:fetch_width-1] slot;
	} fetch_bundle_t;

	typedef enum logic [1:0] {
		idle     = 2'd0,
		train    = 2'd1,
		dispatch = 2'd2
	} lsd_state_t;

	typedef struct packed {
		logic       valid;
		addr_t      start_addr;
		addr_t      fallthrough_addr;
		logic [6:0] num_insts;
		logic [6:0] max_unroll;
	} lat_entry_t;

	typedef struct packed {
		logic       en;
		lat_entry_t entry;
	} lat_write_t;

	// msb is slot 0, so an end in slot 1 gives 4'b1100
	function automatic logic [fetch_width-1:0] lane_mask(input logic [1:0] end_slot);
		logic [fetch_width-1:0] mask;
		mask = '0;
		for (int i = 0; i < fetch_width; i++) begin
			if (i <= int'(end_slot)) begin
				mask[fetch_width-1-i] = 1'b1;
			end
		end
		return mask;
	endfunction

	// iterations of the loop that fit in the buffer
	function automatic logic [6:0] calc_unroll(input logic [6:0] num_insts);
		int unroll;
		if (num_insts == '0 || int'(num_insts) > buffer_size) begin
			unroll = 0;
		end else begin
			unroll = buffer_size / int'(num_insts);
		end
		return 7'(unroll);
	endfunction

endpackage

//--- design/loop_detect/loop_trainer.sv
`timescale 1ns/1ns

module loop_trainer (
	input  logic                   clk,
	input  logic                   rst,
	input  lsd_pkg::fetch_bundle_t bundle,
	input  logic [3:0]             back_loop,
	input  logic                   mispredict,
	input  logic                   lookup_hit,
	input  logic                   dispatching,
	output lsd_pkg::lat_write_t    lat_write,
	output lsd_pkg::lsd_state_t    train_state
);
	import lsd_pkg::*;

	addr_t      fallthrough;
	addr_t      start_addr;
	logic [6:0] count;

	addr_t      flag_addr;
	logic       start_train;
	logic       end_found;
	logic [1:0] end_slot;
	addr_t      start_cur;
	logic [7:0] count_next;

	logic       wr_en;
	lat_entry_t wr_entry;

	// first branch in program order, back_loop[3] is slot 0
	always_comb begin
		flag_addr = bundle.slot[0];
		for (int i = fetch_width - 1; i >= 0; i--) begin
			if (back_loop[fetch_width-1-i]) begin
				flag_addr = bundle.slot[i];
			end
		end
	end

	// lowest slot holding fallthrough - 1
	always_comb begin
		end_found = 1'b0;
		end_slot = '0;
		for (int i = fetch_width - 1; i >= 0; i--) begin
			if (bundle.slot[i] == fallthrough - 16'd1) begin
				end_found = 1'b1;
				end_slot = 2'(i);
			end
		end
	end

	assign start_train = (train_state == idle) && (back_loop != '0) && !lookup_hit &&
		!dispatching;

	// zero count marks the first bundle of the iteration
	assign start_cur = (count == '0) ? bundle.slot[0] : start_addr;
	assign count_next = {1'b0, count} +
		(end_found ? 8'(end_slot) + 8'd1 : 8'(fetch_width));

	always_ff @(posedge clk) begin
		if (rst) begin
			train_state <= idle;
			count <= '0;
			wr_en <= 1'b0;
		end else begin
			wr_en <= 1'b0;
			case (train_state)
				idle: begin
					count <= '0;
					if (start_train) begin
						train_state <= train;
					end
				end
				train: begin
					count <= count_next[6:0];
					if (dispatching || mispredict || count_next > 8'(buffer_size)) begin
						train_state <= idle;
					end else if (end_found) begin
						train_state <= idle;
						wr_en <= 1'b1;
					end
				end
				default: train_state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start_train) begin
			fallthrough <= flag_addr + 16'd1;
		end
		if (train_state == train && count == '0) begin
			start_addr <= bundle.slot[0];
		end
		if (train_state == train && end_found) begin
			wr_entry.valid <= 1'b1;
			wr_entry.start_addr <= start_cur;
			wr_entry.fallthrough_addr <= fallthrough;
			wr_entry.num_insts <= count_next[6:0];
			wr_entry.max_unroll <= calc_unroll(count_next[6:0]);
		end
	end

	assign lat_write = '{en: wr_en, entry: wr_entry};

endmodule

//--- design/loop_detect/loop_addr_table.sv
`timescale 1ns/1ns

module loop_addr_table (
	input  logic                clk,
	input  logic                rst,
	input  lsd_pkg::lat_write_t lat_write,
	input  lsd_pkg::addr_t      lookup_addr,
	output logic                lookup_hit,
	output lsd_pkg::lat_entry_t lookup_entry
);
	import lsd_pkg::*;

	typedef logic [$clog2(lat_depth)-1:0] idx_t;

	lat_entry_t entries [lat_depth];
	idx_t       wr_ptr;

	idx_t       hit_idx;
	idx_t       same_idx;
	idx_t       wr_idx;
	logic       same_hit;

	// parallel match, lowest index wins
	always_comb begin
		lookup_hit = 1'b0;
		hit_idx = '0;
		for (int i = lat_depth - 1; i >= 0; i--) begin
			if (entries[i].valid && entries[i].start_addr == lookup_addr) begin
				lookup_hit = 1'b1;
				hit_idx = idx_t'(i);
			end
		end
	end

	assign lookup_entry = entries[hit_idx];

	// retrained loop replaces its old entry
	always_comb begin
		same_hit = 1'b0;
		same_idx = '0;
		for (int i = lat_depth - 1; i >= 0; i--) begin
			if (entries[i].valid && entries[i].start_addr == lat_write.entry.start_addr) begin
				same_hit = 1'b1;
				same_idx = idx_t'(i);
			end
		end
	end

	assign wr_idx = same_hit ? same_idx : wr_ptr;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			for (int i = 0; i < lat_depth; i++) begin
				entries[i].valid <= 1'b0;
			end
		end else if (lat_write.en) begin
			entries[wr_idx] <= lat_write.entry;
			// round robin victim only moves on a new loop
			if (!same_hit) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
		end
	end

endmodule

//--- design/dispatch_ctrl.sv
`timescale 1ns/1ns

module dispatch_ctrl (
	input  logic                   clk,
	input  logic                   rst,
	input  lsd_pkg::fetch_bundle_t bundle,
	input  logic                   mispredict,
	input  logic                   lookup_hit,
	input  lsd_pkg::lat_entry_t    lookup_entry,
	output logic                   dispatching,
	output logic                   loop_start,
	output logic                   finish_unroll,
	output logic                   stall_fetch,
	output logic [3:0]             lane_valid
);
	import lsd_pkg::*;

	lsd_state_t state;
	addr_t      fallthrough;
	logic [6:0] unroll_left;
	logic [6:0] issued;

	logic       end_found;
	logic [1:0] end_slot;
	logic [3:0] mask;
	logic [7:0] issued_sum;

	always_comb begin
		end_found = 1'b0;
		end_slot = '0;
		for (int i = fetch_width - 1; i >= 0; i--) begin
			if (bundle.slot[i] == fallthrough - 16'd1) begin
				end_found = 1'b1;
				end_slot = 2'(i);
			end
		end
	end

	assign mask = end_found ? lane_mask(end_slot) : 4'b1111;
	assign issued_sum = {1'b0, issued} + 8'($countones(mask));
	assign dispatching = (state != idle);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
			loop_start <= 1'b0;
			finish_unroll <= 1'b0;
			stall_fetch <= 1'b0;
			lane_valid <= 4'b1111;
			issued <= '0;
			unroll_left <= '0;
		end else begin
			loop_start <= 1'b0;
			finish_unroll <= 1'b0;
			if (state == idle) begin
				lane_valid <= 4'b1111;
				issued <= '0;
				stall_fetch <= 1'b0;
				if (lookup_hit && !mispredict) begin
					state <= dispatch;
					loop_start <= 1'b1;
					unroll_left <= lookup_entry.max_unroll;
				end
			end else if (mispredict) begin
				state <= idle;
				lane_valid <= 4'b1111;
			end else begin
				lane_valid <= mask;
				// counter saturates at the buffer size
				if (issued_sum >= 8'(buffer_size)) begin
					issued <= 7'(buffer_size);
					stall_fetch <= 1'b1;
				end else begin
					issued <= issued_sum[6:0];
				end
				if (end_found) begin
					unroll_left <= unroll_left - 7'd1;
					if (unroll_left <= 7'd1) begin
						state <= idle;
						finish_unroll <= 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == idle && lookup_hit) begin
			fallthrough <= lookup_entry.fallthrough_addr;
		end
	end

endmodule

//--- design/loop_stream_top.sv
`timescale 1ns/1ns

module loop_stream_top (
	input  logic                   clk,
	input  logic                   rst,
	input  lsd_pkg::fetch_bundle_t bundle,
	input  logic [3:0]             back_loop,
	input  logic                   mispredict,
	output lsd_pkg::lsd_state_t    lsd_state,
	output logic                   loop_start,
	output logic                   finish_unroll,
	output logic                   stall_fetch,
	output logic [3:0]             lane_valid
);
	import lsd_pkg::*;

	lat_write_t lat_write;
	logic       lookup_hit;
	lat_entry_t lookup_entry;
	logic       dispatching;
	lsd_state_t train_state;

	loop_trainer u_trainer (
		.clk         (clk),
		.rst         (rst),
		.bundle      (bundle),
		.back_loop   (back_loop),
		.mispredict  (mispredict),
		.lookup_hit  (lookup_hit),
		.dispatching (dispatching),
		.lat_write   (lat_write),
		.train_state (train_state)
	);

	// lookup keyed on the oldest slot of the bundle
	loop_addr_table u_table (
		.clk          (clk),
		.rst          (rst),
		.lat_write    (lat_write),
		.lookup_addr  (bundle.slot[0]),
		.lookup_hit   (lookup_hit),
		.lookup_entry (lookup_entry)
	);

	dispatch_ctrl u_dispatch (
		.clk           (clk),
		.rst           (rst),
		.bundle        (bundle),
		.mispredict    (mispredict),
		.lookup_hit    (lookup_hit),
		.lookup_entry  (lookup_entry),
		.dispatching   (dispatching),
		.loop_start    (loop_start),
		.finish_unroll (finish_unroll),
		.stall_fetch   (stall_fetch),
		.lane_valid    (lane_valid)
	);

	assign lsd_state = dispatching ? dispatch : train_state;

endmodule

//--- verification/loop_stream_assert.sv
`timescale 1ns/1ns

module loop_stream_assert (
	input logic                clk,
	input logic                rst,
	input lsd_pkg::lsd_state_t lsd_state,
	input logic                loop_start,
	input logic                finish_unroll,
	input logic                stall_fetch
);
	import lsd_pkg::*;

	// entering and leaving a loop are separate events
	start_not_finish: assert property (
		@(posedge clk) disable iff (rst) !(loop_start && finish_unroll)
	) else $error("loop_start and finish_unroll high in the same cycle");

	start_single_pulse: assert property (
		@(posedge clk) disable iff (rst) loop_start |=> !loop_start
	) else $error("loop_start held longer than one cycle");

	// stall released only by the idle controller
	stall_release_idle: assert property (
		@(posedge clk) disable iff (rst) $fell(stall_fetch) |-> $past(lsd_state) != dispatch
	) else $error("stall_fetch dropped while dispatching");

endmodule

//--- verification/loop_stream_tb.sv
`timescale 1ns/1ns

module loop_stream_tb;
	import lsd_pkg::*;

	typedef struct packed {
		fetch_bundle_t bundle;
		logic [3:0]    back_loop;
		logic          mispredict;
		lsd_state_t    state;
		logic          start;
		logic          finish;
		logic          stall;
		logic [3:0]    lane;
	} row_t;

	logic          clk;
	logic          rst;
	fetch_bundle_t bundle;
	logic [3:0]    back_loop;
	logic          mispredict;
	lsd_state_t    lsd_state;
	logic          loop_start;
	logic          finish_unroll;
	logic          stall_fetch;
	logic [3:0]    lane_valid;

	row_t       rows[$];
	addr_t      bases[8];
	int         cycles = 0;
	int         cycle_limit = 1000000;

	// outputs expected in the cycle of the next pushed row
	lsd_state_t exp_state;
	logic       exp_start;
	logic       exp_finish;
	logic       exp_stall;
	logic [3:0] exp_lane;

	loop_stream_top dut (
		.clk           (clk),
		.rst           (rst),
		.bundle        (bundle),
		.back_loop     (back_loop),
		.mispredict    (mispredict),
		.lsd_state     (lsd_state),
		.loop_start    (loop_start),
		.finish_unroll (finish_unroll),
		.stall_fetch   (stall_fetch),
		.lane_valid    (lane_valid)
	);

	bind loop_stream_top loop_stream_assert u_assert (
		.clk           (clk),
		.rst           (rst),
		.lsd_state     (lsd_state),
		.loop_start    (loop_start),
		.finish_unroll (finish_unroll),
		.stall_fetch   (stall_fetch)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit) begin
			$display("timeout: the stimulus table did not finish in %0d cycles", cycles);
			$display("TESTS FAILED");
			$fatal(1, "timeout");
		end
	end

	function automatic fetch_bundle_t seq_bundle(input addr_t pc);
		fetch_bundle_t b;
		for (int i = 0; i < fetch_width; i++) begin
			b.slot[i] = pc + 16'(i);
		end
		return b;
	endfunction

	// far away from every loop region
	function automatic fetch_bundle_t park_bundle();
		return seq_bundle(16'hf000);
	endfunction

	function automatic int find_end(input fetch_bundle_t b, input addr_t last);
		for (int i = 0; i < fetch_width; i++) begin
			if (b.slot[i] == last) begin
				return i;
			end
		end
		return -1;
	endfunction

	task automatic set_idle();
		exp_state = idle;
		exp_start = 1'b0;
		exp_finish = 1'b0;
		exp_stall = 1'b0;
		exp_lane = 4'b1111;
	endtask

	task automatic push_row(input fetch_bundle_t b, input logic [3:0] bl, input logic mp);
		row_t r;
		r.bundle = b;
		r.back_loop = bl;
		r.mispredict = mp;
		r.state = exp_state;
		r.start = exp_start;
		r.finish = exp_finish;
		r.stall = exp_stall;
		r.lane = exp_lane;
		rows.push_back(r);
	endtask

	task automatic step_idle(input fetch_bundle_t b);
		push_row(b, 4'b0000, 1'b0);
		set_idle();
	endtask

	// branch in slot 3 of the bundle just before the first iteration
	task automatic train_loop(input addr_t base, input int n, input logic abort);
		addr_t pc;
		logic  done;
		push_row(seq_bundle(base + 16'(n) - 16'd4), 4'b0001, 1'b0);
		exp_state = train;
		pc = base;
		done = 1'b0;
		while (!done) begin
			done = abort || (find_end(seq_bundle(pc), base + 16'(n) - 16'd1) >= 0);
			push_row(seq_bundle(pc), 4'b0000, abort);
			pc = pc + 16'd4;
		end
		set_idle();
		// write strobe cycle
		step_idle(park_bundle());
	endtask

	task automatic dispatch_loop(input addr_t base, input int n, input int abort_at);
		fetch_bundle_t b;
		addr_t         pc;
		int            slot;
		int            unroll;
		int            issued;
		int            k;
		logic [3:0]    mask;
		b = seq_bundle(base);
		push_row(b, 4'b0000, 1'b0);
		pc = (find_end(b, base + 16'(n) - 16'd1) >= 0) ? base : base + 16'd4;
		exp_state = dispatch;
		exp_start = 1'b1;
		unroll = int'(calc_unroll(7'(n)));
		issued = 0;
		k = 0;
		while (exp_state == dispatch) begin
			b = seq_bundle(pc);
			slot = find_end(b, base + 16'(n) - 16'd1);
			push_row(b, 4'b0000, k == abort_at);
			exp_start = 1'b0;
			if (k == abort_at) begin
				exp_state = idle;
				exp_lane = 4'b1111;
			end else begin
				mask = (slot < 0) ? 4'b1111 : lane_mask(2'(slot));
				exp_lane = mask;
				issued += $countones(mask);
				exp_stall = (issued >= buffer_size);
				pc = (slot < 0) ? pc + 16'd4 : base;
				if (slot >= 0) begin
					unroll--;
					if (unroll == 0) begin
						exp_state = idle;
						exp_finish = 1'b1;
					end
				end
			end
			k++;
		end
		step_idle(park_bundle());
	endtask

	task automatic check_state(input string name, input lsd_state_t got, input lsd_state_t want);
		if (got !== want) begin
			$display("ERROR %0t ns: %s is %0d, expected %0d", $time, name, got, want);
			$display("TESTS FAILED");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		if (got !== want) begin
			$display("ERROR %0t ns: %s is %b, expected %b", $time, name, got, want);
			$display("TESTS FAILED");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	task automatic check_lane(input string name, input logic [3:0] got, input logic [3:0] want);
		if (got !== want) begin
			$display("ERROR %0t ns: %s is %b, expected %b", $time, name, got, want);
			$display("TESTS FAILED");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	task automatic check_outputs(input row_t r);
		check_state("lsd_state", lsd_state, r.state);
		check_bit("loop_start", loop_start, r.start);
		check_bit("finish_unroll", finish_unroll, r.finish);
		check_bit("stall_fetch", stall_fetch, r.stall);
		check_lane("lane_valid", lane_valid, r.lane);
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		bundle = park_bundle();
		back_loop = 4'b0000;
		mispredict = 1'b0;
		void'($urandom(32'h633d_43c9));
		for (int k = 0; k < 8; k++) begin
			bases[k] = 16'((k + 1) << 12) | 16'($urandom & 32'h7f0);
		end

		set_idle();
		step_idle(park_bundle());
		train_loop(bases[0], 6, 1'b0);
		dispatch_loop(bases[0], 6, -1);
		// 32 passes of two instructions fill the buffer
		train_loop(bases[1], 2, 1'b0);
		dispatch_loop(bases[1], 2, -1);
		// refetch after aborted training must not dispatch
		train_loop(bases[2], 6, 1'b1);
		step_idle(seq_bundle(bases[2]));
		step_idle(park_bundle());
		dispatch_loop(bases[0], 6, 5);
		// five new loops evict the oldest of them
		for (int k = 3; k < 8; k++) begin
			train_loop(bases[k], k, 1'b0);
		end
		step_idle(seq_bundle(bases[3]));
		step_idle(park_bundle());
		dispatch_loop(bases[7], 7, -1);
		cycle_limit = rows.size() + 20;

		// reset spans three edges and the third opens row 0
		for (int k = 0; k < 2; k++) begin
			@(posedge clk);
			#90;
			check_outputs(rows[0]);
		end
		for (int i = 0; i < rows.size(); i++) begin
			@(posedge clk);
			#5;
			rst = 1'b0;
			bundle = rows[i].bundle;
			back_loop = rows[i].back_loop;
			mispredict = rows[i].mispredict;
			#85;
			check_outputs(rows[i]);
		end
		$display("TESTS PASSED");
		$finish;
	end

endmodule

//--- all.f
common/lsd_pkg.sv
design/loop_detect/loop_trainer.sv
design/loop_detect/loop_addr_table.sv
design/dispatch_ctrl.sv
design/loop_stream_top.sv
verification/loop_stream_assert.sv
verification/loop_stream_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the loop stream detector testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
	-f all.f --top-module loop_stream_tb -o loop_stream_sim &&
./obj_dir/loop_stream_sim ||
{ echo "simulation failed"; exit 1; }
